//--- rtl/bldc_pkg.sv
// Hall codes assume 120-degree sensor spacing; 000 and 111 are treated as invalid everywhere
`default_nettype none

package bldc_pkg;

    // Sector code and gate drive word
    typedef logic [2:0] hall_t;
    typedef logic [5:0] gate_t;

    // States of the 30-degree delay FSM
    typedef enum logic [2:0] {
        RESET,
        INIT,
        CHANGE_POSITION,
        DELAY_30,
        APPLY_CHANGE,
        IDLE
    } delay_state_t;

    // True for the six codes a healthy sensor set can produce
    function automatic logic hall_valid(input hall_t code);
        return (code != 3'b000) && (code != 3'b111);
    endfunction

    // Successor of each sector in rotation order
    function automatic hall_t next_sector(input hall_t code);
        hall_t nxt;
        case (code)
            3'b101:  nxt = 3'b100;
            3'b100:  nxt = 3'b110;
            3'b110:  nxt = 3'b010;
            3'b010:  nxt = 3'b011;
            3'b011:  nxt = 3'b001;
            3'b001:  nxt = 3'b101;
            default: nxt = code;
        endcase
        return nxt;
    endfunction

    // Six-step table with one hot phase per side, bit 0 is phase A
    function automatic gate_t sector_gates(input hall_t code, input logic reverse);
        logic [2:0] hi;
        logic [2:0] lo;
        case (code)
            3'b101:  {hi, lo} = {3'b001, 3'b010};
            3'b100:  {hi, lo} = {3'b001, 3'b100};
            3'b110:  {hi, lo} = {3'b010, 3'b100};
            3'b010:  {hi, lo} = {3'b010, 3'b001};
            3'b011:  {hi, lo} = {3'b100, 3'b001};
            3'b001:  {hi, lo} = {3'b100, 3'b010};
            default: {hi, lo} = 6'b000000;
        endcase
        // Reverse rotation swaps which phase sources and which sinks
        if (reverse)
        begin
            return {lo, hi};
        end
        return {hi, lo};
    endfunction

endpackage

`default_nettype wire

//--- rtl/hall_sync.sv
// Raw Hall lines are asynchronous; a new code is accepted after FILTER_LEN equal samples
`timescale 1ns/100ps
`default_nettype none

module hall_sync
    import bldc_pkg::*;
#(
    parameter int FILTER_LEN = 4
)
(
    input  wire logic       clk_i,
    input  wire logic       rst_i,
    input  wire logic [2:0] hall_i,
    output hall_t           hall_o,
    output logic            fault_o
);

    localparam int CNT_BITS = $clog2(FILTER_LEN + 1);
    localparam logic [CNT_BITS-1:0] FILT_MAX = CNT_BITS'(FILTER_LEN);

    // Synchronizer stages
    hall_t sync1;
    hall_t sync2;

    // Candidate code and how many samples it has held
    hall_t cand;
    logic [CNT_BITS-1:0] stable_cnt;

    // --------------------
    // Synchronizer
    // --------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            sync1 <= 3'b001;
            sync2 <= 3'b001;
        end
        else
        begin
            sync1 <= hall_i;
            sync2 <= sync1;
        end
    end

    // --------------------
    // Stability filter
    // --------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            cand       <= 3'b001;
            stable_cnt <= '0;
            hall_o     <= 3'b001;
        end
        else if (sync2 != cand)
        begin
            // New candidate, this sample counts as the first
            cand       <= sync2;
            stable_cnt <= CNT_BITS'(1);
        end
        else
        begin
            if (stable_cnt != FILT_MAX)
            begin
                stable_cnt <= stable_cnt + 1'b1;
            end
            // Held long enough and still present
            if (stable_cnt == FILT_MAX)
            begin
                hall_o <= cand;
            end
        end
    end

    // Fault while filtered code is one of the two impossible patterns
    assign fault_o = !hall_valid(hall_o);

endmodule

`default_nettype wire

//--- rtl/hall_delay_30.sv
// Delay assumes near-constant speed between edges; counter saturates below 2**CNT_W cycles
`timescale 1ns/100ps
`default_nettype none

module hall_delay_30
    import bldc_pkg::*;
#(
    parameter int CNT_W = 24
)
(
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire hall_t position_i,
    output hall_t      position_o
);

    localparam logic [CNT_W-1:0] CNT_MAX = '1;

    delay_state_t state;
    delay_state_t next_state;

    // Last applied sector
    hall_t position_old;

    // Interval measurement and half-interval wait
    logic [CNT_W-1:0] speed_count;
    logic [CNT_W-1:0] speed_divider;
    logic [CNT_W-1:0] delay_count;

    // New valid sector seen at the input
    logic pos_change;

    assign pos_change = hall_valid(position_i) && (position_i != position_old);

    // --------------------
    // State register
    // --------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state <= RESET;
        end
        else
        begin
            state <= next_state;
        end
    end

    // --------------------
    // Next state
    // --------------------
    always_comb
    begin
        next_state = state;
        case (state)
            RESET:
            begin
                next_state = INIT;
            end
            INIT, IDLE:
            begin
                if (pos_change)
                begin
                    next_state = CHANGE_POSITION;
                end
            end
            CHANGE_POSITION:
            begin
                next_state = DELAY_30;
            end
            DELAY_30:
            begin
                // Half of the last interval is 30 electrical degrees
                if (delay_count > speed_divider)
                begin
                    next_state = APPLY_CHANGE;
                end
            end
            APPLY_CHANGE:
            begin
                next_state = IDLE;
            end
            default:
            begin
                next_state = RESET;
            end
        endcase
    end

    // --------------------
    // Datapath
    // --------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i || (state == RESET))
        begin
            speed_count   <= '0;
            speed_divider <= '0;
            delay_count   <= '0;
            position_old  <= 3'b001;
            position_o    <= 3'b001;
        end
        else if (state == CHANGE_POSITION)
        begin
            // Latch half interval and restart both counters
            speed_divider <= speed_count >> 1;
            speed_count   <= '0;
            delay_count   <= '0;
        end
        else
        begin
            // Saturating interval count in every other state
            if (speed_count != CNT_MAX)
            begin
                speed_count <= speed_count + 1'b1;
            end
            if (state == DELAY_30)
            begin
                delay_count <= delay_count + 1'b1;
            end
            // Invalid code here keeps the previous sector
            if ((state == APPLY_CHANGE) && hall_valid(position_i))
            begin
                position_o   <= next_sector(position_i);
                position_old <= position_i;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/pwm_gen.sv
// Edge-aligned carrier with period 2**DUTY_W cycles; duty changes take effect at any count
`timescale 1ns/100ps
`default_nettype none

module pwm_gen
#(
    parameter int DUTY_W = 8
)
(
    input  wire logic              clk_i,
    input  wire logic              rst_i,
    input  wire logic [DUTY_W-1:0] duty_i,
    output logic                   pwm_o
);

    // Free-running carrier, wraps naturally
    logic [DUTY_W-1:0] carrier;

    // --------------------
    // Carrier counter
    // --------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            carrier <= '0;
        end
        else
        begin
            carrier <= carrier + 1'b1;
        end
    end

    // --------------------
    // Duty compare
    // --------------------
    // High for duty_i counts per period
    // Zero duty stays low, full scale misses one count
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            pwm_o <= 1'b0;
        end
        else
        begin
            pwm_o <= (carrier < duty_i);
        end
    end

endmodule

`default_nettype wire

//--- rtl/commutation_table.sv
// No dead time is inserted; high and low switches of one phase are never on together
`timescale 1ns/100ps
`default_nettype none

module commutation_table
    import bldc_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  rst_i,
    input  wire hall_t sector_i,
    input  wire logic  dir_i,
    input  wire logic  enable_i,
    input  wire logic  fault_i,
    input  wire logic  pwm_i,
    output gate_t      gate_o
);

    // Raw table entry for the current sector
    gate_t table_gates;

    // Entry after PWM chopping and blanking
    gate_t gate_next;

    // --------------------
    // Table lookup
    // --------------------
    always_comb
    begin
        // dir_i high selects reverse rotation
        table_gates = sector_gates(sector_i, dir_i);
    end

    always_comb
    begin
        if (!enable_i || fault_i)
        begin
            // All switches open
            gate_next = '0;
        end
        else
        begin
            // Chop only the high side
            gate_next[5:3] = table_gates[5:3] & {3{pwm_i}};
            gate_next[2:0] = table_gates[2:0];
        end
    end

    // --------------------
    // Output register
    // --------------------
    // Keeps decode glitches off the gate lines
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            gate_o <= '0;
        end
        else
        begin
            gate_o <= gate_next;
        end
    end

endmodule

`default_nettype wire

//--- rtl/bldc_commutation_top.sv
// Sensored six-step path only; no current limit, dead time or register access is provided
`timescale 1ns/100ps
`default_nettype none

module bldc_commutation_top
    import bldc_pkg::*;
#(
    parameter int FILTER_LEN = 4,
    parameter int CNT_W      = 24,
    parameter int DUTY_W     = 8
)
(
    input  wire logic              clk_i,
    input  wire logic              rst_i,
    input  wire logic [2:0]        hall_i,
    input  wire logic [DUTY_W-1:0] duty_i,
    input  wire logic              dir_i,
    input  wire logic              enable_i,
    output wire gate_t             gate_o,
    output wire hall_t             sector_o,
    output wire logic              hall_fault_o
);

    // Filtered sensor code and its fault flag
    wire hall_t hall_filt;
    wire logic  fault;

    // Chopper level
    wire logic  pwm;

    // --------------------
    // Hall input filter
    // --------------------
    hall_sync #(
        .FILTER_LEN (FILTER_LEN)
    ) u_hall_sync (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .hall_i  (hall_i),
        .hall_o  (hall_filt),
        .fault_o (fault)
    );

    // Sector advanced by 30 degrees
    hall_delay_30 #(
        .CNT_W (CNT_W)
    ) u_hall_delay_30 (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .position_i (hall_filt),
        .position_o (sector_o)
    );

    // --------------------
    // PWM and gate decode
    // --------------------
    pwm_gen #(
        .DUTY_W (DUTY_W)
    ) u_pwm_gen (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .duty_i (duty_i),
        .pwm_o  (pwm)
    );

    commutation_table u_commutation_table (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .sector_i (sector_o),
        .dir_i    (dir_i),
        .enable_i (enable_i),
        .fault_i  (fault),
        .pwm_i    (pwm),
        .gate_o   (gate_o)
    );

    assign hall_fault_o = fault;

endmodule

`default_nettype wire

//--- dv/tb_bldc_model.svh
// Needs FILTER_LEN, DUTY_W and a fail_run task in the including module before use
`ifndef TB_BLDC_MODEL_SVH
`define TB_BLDC_MODEL_SVH

// --------------------
// Sector rotation
// --------------------
// Forward rotation order of the six valid codes
function automatic hall_t seq_code(input int idx);
    case (idx % 6)
        0:       return 3'b101;
        1:       return 3'b100;
        2:       return 3'b110;
        3:       return 3'b010;
        4:       return 3'b011;
        default: return 3'b001;
    endcase
endfunction

// Position in the rotation, -1 for 000 and 111
function automatic int seq_index(input hall_t code);
    for (int i = 0; i < 6; i++)
    begin
        if (seq_code(i) == code)
        begin
            return i;
        end
    end
    return -1;
endfunction

function automatic hall_t model_next(input hall_t code);
    int idx;
    idx = seq_index(code);
    if (idx < 0)
    begin
        return code;
    end
    return seq_code(idx + 1);
endfunction

// Six-step word, phase A at bit 0 of each side
// High phase steps every two sectors, low phase trails by one sector
function automatic gate_t model_gates(input hall_t code, input logic rev);
    int         idx;
    logic [2:0] hi;
    logic [2:0] lo;
    idx = seq_index(code);
    if (idx < 0)
    begin
        return '0;
    end
    hi = 3'b001 << (idx / 2);
    lo = 3'b001 << (((idx + 1) / 2 + 1) % 3);
    return rev ? {lo, hi} : {hi, lo};
endfunction

// --------------------
// Timing rules
// --------------------
function automatic int filter_latency();
    return FILTER_LEN + 3;
endfunction

// Bounds of the delayed change, in cycles after the raw edge
function automatic int window_lo(input int prev);
    return prev / 2;
endfunction

function automatic int window_hi(input int prev);
    return prev / 2 + FILTER_LEN + 10;
endfunction

function automatic int pwm_period();
    return 1 << DUTY_W;
endfunction

// --------------------
// Compare tasks
// --------------------
task automatic check_hall(input string name, input hall_t got, input hall_t exp);
    if (got !== exp)
    begin
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        fail_run("Hall code mismatch");
    end
endtask

task automatic check_gate(input string name, input gate_t got, input gate_t exp);
    if (got !== exp)
    begin
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        fail_run("Gate word mismatch");
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        fail_run("Flag mismatch");
    end
endtask

task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
    begin
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        fail_run("Count mismatch");
    end
endtask

`endif

//--- dv/tb_bldc_commutation.sv
// Hall edges are spaced at least half the last interval plus 20 cycles apart
`timescale 1ns/100ps
`default_nettype none

module tb_bldc_commutation
    import bldc_pkg::*;
();

    localparam int FILTER_LEN = 4;
    localparam int CNT_W      = 24;
    localparam int DUTY_W     = 8;
    localparam int EDGES      = 14;
    localparam int DUTY_RUNS  = 6;

    logic              clk_i;
    logic              rst_i;
    logic [2:0]        hall_i;
    logic [DUTY_W-1:0] duty_i;
    logic              dir_i;
    logic              enable_i;
    gate_t             gate_o;
    hall_t             sector_o;
    logic              hall_fault_o;

    integer seed;
    int     cyc;

    // Monitor copies from the previous falling edge
    hall_t mon_sector;
    logic  mon_dir;
    logic  mon_enable;
    logic  mon_fault;
    logic  mon_armed;

    `include "tb_bldc_model.svh"

    bldc_commutation_top #(
        .FILTER_LEN (FILTER_LEN),
        .CNT_W      (CNT_W),
        .DUTY_W     (DUTY_W)
    ) dut_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .hall_i       (hall_i),
        .duty_i       (duty_i),
        .dir_i        (dir_i),
        .enable_i     (enable_i),
        .gate_o       (gate_o),
        .sector_o     (sector_o),
        .hall_fault_o (hall_fault_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever
        begin
            #2 clk_i = ~clk_i;
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    // One clock, then the point where outputs are sampled and inputs change
    task automatic tick();
        @(posedge clk_i);
        #1;
        cyc = cyc + 1;
    endtask

    // Fixed number of cycles with the sector steady and no fault
    task automatic hold_sector(input int cycles, input hall_t sector);
        for (int i = 0; i < cycles; i++)
        begin
            tick();
            check_hall("sector_o", sector_o, sector);
            check_bit("hall_fault_o", hall_fault_o, 1'b0);
        end
    endtask

    // --------------------
    // Gate decode monitor
    // --------------------
    task automatic check_decode();
        gate_t exp;
        exp = model_gates(mon_sector, mon_dir);
        if (!mon_enable || mon_fault)
        begin
            check_gate("gate_o", gate_o, '0);
        end
        else
        begin
            check_gate("gate_o low side", gate_o & 6'b000111, exp & 6'b000111);
            // PWM may clear high bits, never add them
            check_gate("gate_o high side", gate_o & ~exp & 6'b111000, '0);
        end
    endtask

    always @(negedge clk_i)
    begin
        if (rst_i)
        begin
            mon_armed = 1'b0;
        end
        else
        begin
            if (mon_armed)
            begin
                check_decode();
            end
            mon_sector = sector_o;
            mon_dir    = dir_i;
            mon_enable = enable_i;
            mon_fault  = hall_fault_o;
            mon_armed  = 1'b1;
        end
    end

    // --------------------
    // Hall scenarios
    // --------------------
    task automatic wait_sector_change(input hall_t old, input int prev);
        int n;
        n = 0;
        while ((sector_o == old) && (n < window_hi(prev)))
        begin
            tick();
            n = n + 1;
            check_bit("hall_fault_o", hall_fault_o, 1'b0);
        end
        if (sector_o == old)
        begin
            fail_run($sformatf("Timeout: sector_o unchanged %0d cycles after the Hall edge",
                               window_hi(prev)));
        end
        else if (n < window_lo(prev))
        begin
            fail_run($sformatf("sector_o changed %0d cycles after the Hall edge, before %0d",
                               n, window_lo(prev)));
        end
    endtask

    // Pulse shorter than the filter to any other code
    task automatic glitch_test(input hall_t steady, input hall_t sector);
        hall_t glitch;
        int    len;
        glitch = $random(seed);
        if (glitch == steady)
        begin
            glitch = ~steady;
        end
        len = 1 + ($unsigned($random(seed)) % (FILTER_LEN - 1));
        hall_i = glitch;
        hold_sector(len, sector);
        hall_i = steady;
        hold_sector(filter_latency() + 2, sector);
    endtask

    // Invalid code held long, then the same valid code restored
    task automatic fault_test(input hall_t steady, input hall_t sector);
        int n;
        hall_i = ($random(seed) & 1) ? 3'b111 : 3'b000;
        n = 0;
        while (!hall_fault_o && (n < filter_latency()))
        begin
            tick();
            n = n + 1;
            check_hall("sector_o", sector_o, sector);
        end
        if (!hall_fault_o)
        begin
            fail_run("Timeout: hall_fault_o did not rise for an invalid Hall code");
        end
        if (n != filter_latency())
        begin
            fail_run($sformatf("hall_fault_o rose after %0d cycles, not %0d", n, filter_latency()));
        end
        for (int i = 0; i < 12; i++)
        begin
            tick();
            check_bit("hall_fault_o", hall_fault_o, 1'b1);
            check_hall("sector_o", sector_o, sector);
            check_gate("gate_o", gate_o, '0);
        end
        hall_i = steady;
        n = 0;
        while (hall_fault_o && (n < filter_latency()))
        begin
            tick();
            n = n + 1;
            check_hall("sector_o", sector_o, sector);
        end
        if (hall_fault_o)
        begin
            fail_run("Timeout: hall_fault_o stayed high after the valid code returned");
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial
    begin
        hall_t cur_raw;
        hall_t cur_sector;
        int    interval;
        int    prev_interval;
        int    edge_cyc;
        int    n;

        seed      = 32'h31ba;
        cyc       = 0;
        mon_armed = 1'b0;
        rst_i     = 1'b1;
        hall_i    = 3'b001;
        duty_i    = 8'd128;
        dir_i     = 1'b0;
        enable_i  = 1'b1;
        for (int i = 0; i < 10; i++)
        begin
            tick();
        end
        rst_i = 1'b0;

        check_hall("sector_o", sector_o, 3'b001);
        check_gate("gate_o", gate_o, '0);
        check_bit("hall_fault_o", hall_fault_o, 1'b0);

        cur_raw    = 3'b001;
        cur_sector = 3'b001;
        hold_sector(60, cur_sector);
        // Interval counter also covers the reset tail
        prev_interval = 60 + 8;

        for (int e = 0; e < EDGES; e++)
        begin
            interval = 40 + ($unsigned($random(seed)) % 361);
            if (interval < prev_interval / 2 + 20)
            begin
                interval = prev_interval / 2 + 20;
            end
            // Long interval leaves room for the fault case
            if (e == 5)
            begin
                interval = 400;
            end
            cur_raw  = model_next(cur_raw);
            hall_i   = cur_raw;
            dir_i    = $random(seed);
            edge_cyc = cyc;
            wait_sector_change(cur_sector, prev_interval);
            cur_sector = model_next(cur_raw);
            check_hall("sector_o", sector_o, cur_sector);
            if (e == 5)
            begin
                fault_test(cur_raw, cur_sector);
            end
            else if (edge_cyc + interval - cyc > 40)
            begin
                glitch_test(cur_raw, cur_sector);
            end
            hold_sector(edge_cyc + interval - cyc, cur_sector);
            prev_interval = interval;
        end

        // Duty held steady, high side counted over one full period
        for (int r = 0; r < DUTY_RUNS; r++)
        begin
            if (r == 0)
            begin
                duty_i = '0;
            end
            else if (r == 1)
            begin
                duty_i = '1;
            end
            else
            begin
                duty_i = $random(seed);
            end
            hold_sector(4, cur_sector);
            n = 0;
            for (int c = 0; c < pwm_period(); c++)
            begin
                tick();
                check_hall("sector_o", sector_o, cur_sector);
                if (gate_o[5:3] != 3'b000)
                begin
                    n = n + 1;
                end
            end
            check_count("high side active cycles", n, int'(duty_i));
        end

        // Low side is always on while enabled, so zero means blanked
        enable_i = 1'b0;
        n = 0;
        while ((gate_o != '0) && (n < 2))
        begin
            tick();
            n = n + 1;
        end
        if (gate_o != '0)
        begin
            fail_run("Timeout: gate_o not cleared within two cycles of enable_i low");
        end
        hold_sector(10, cur_sector);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+dv
rtl/bldc_pkg.sv
rtl/hall_sync.sv
rtl/hall_delay_30.sv
rtl/pwm_gen.sv
rtl/commutation_table.sv
rtl/bldc_commutation_top.sv
dv/tb_bldc_commutation.sv
